// File: logic/bridge_pkg.sv
package bridge_pkg;

   // =========================================================================
   // dead time lengths, in ADA_DCO cycles
   // =========================================================================

   localparam int DT_CYC_80 = 80;
   localparam int DT_CYC_20 = 20;
   localparam int DT_CYC_40 = 40;
   localparam int DT_CYC_60 = 60;

   // per-switch run counter, wide enough for the longest dead time
   localparam int DT_W = 7;

   // =========================================================================
   // start-up sequence
   // =========================================================================

   // clock cycles per start-up tick
   localparam int STARTUP_DIV = 8;
   // boot ends once the tick count exceeds this
   localparam int ON_TICKS = 10;
   // normal switching once the tick count exceeds this
   localparam int VG_TICKS = 16;
   localparam int CNT_W = 8;

   // =========================================================================
   // types
   // =========================================================================

   // leg 1 is q1/q3, leg 2 is q2/q4
   typedef struct packed {
      logic q4;
      logic q3;
      logic q2;
      logic q1;
   } gate_t;

   typedef enum logic [1:0] {
      PH_OFF   = 2'b00,
      PH_BOOT  = 2'b01,
      PH_FORCE = 2'b10,
      PH_RUN   = 2'b11
   } phase_t;

   // codes match the switch encoding of the board
   typedef enum logic [1:0] {
      DT_80 = 2'b00,
      DT_40 = 2'b01,
      DT_20 = 2'b10,
      DT_60 = 2'b11
   } dt_sel_t;

   // both low sides on, bootstrap caps charging
   localparam gate_t GATE_BOOT  = '{q4: 1'b1, q3: 1'b1, q2: 1'b0, q1: 1'b0};
   // push the tank into sigma = 1
   localparam gate_t GATE_FORCE = '{q4: 1'b1, q3: 1'b0, q2: 1'b0, q1: 1'b1};

endpackage

// File: logic/startup_sequencer.sv
`timescale 1ns/1ps

module startup_sequencer
   import bridge_pkg::*;
(
   input  logic   ADA_DCO,
   input  logic   i_rst_n,
   input  logic   i_enable,
   output phase_t o_phase
);

   // =========================================================================
   // prescaler and tick counter
   // =========================================================================

   // cycle count inside the current tick
   logic [CNT_W-1:0] pre_cnt;
   // start-up ticks since enable
   logic [CNT_W-1:0] tick_cnt;

   logic pre_wrap;
   logic on_done;
   logic vg_done;
   logic cnt_en;

   // last cycle of a tick
   assign pre_wrap = (pre_cnt == CNT_W'(STARTUP_DIV - 1));

   // thresholds against the ON and VG tick counts
   assign on_done = (tick_cnt > CNT_W'(ON_TICKS));
   assign vg_done = (tick_cnt > CNT_W'(VG_TICKS));

   // counter freezes once VG is reached
   assign cnt_en = i_enable & ~vg_done;

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pre_cnt  <= '0;
         tick_cnt <= '0;
      end else if (!i_enable) begin
         // disabled so the next enable starts from tick zero
         pre_cnt  <= '0;
         tick_cnt <= '0;
      end else if (cnt_en) begin
         if (pre_wrap) begin
            pre_cnt  <= '0;
            tick_cnt <= tick_cnt + 1'b1;
         end else begin
            pre_cnt <= pre_cnt + 1'b1;
         end
      end
   end

   // =========================================================================
   // phase decode
   // =========================================================================

   // look-ahead phase that the gate driver takes into a register
   // so the registered phase sees BOOT the cycle after enable is sampled
   always_comb begin
      if (!i_enable) begin
         o_phase = PH_OFF;
      end else if (vg_done) begin
         o_phase = PH_RUN;
      end else if (on_done) begin
         o_phase = PH_FORCE;
      end else begin
         o_phase = PH_BOOT;
      end
   end

   // a restart has to go through OFF since the counter only clears there
   property p_run_not_to_boot;
      @(posedge ADA_DCO) disable iff (!i_rst_n)
         (o_phase == PH_RUN) |=> (o_phase != PH_BOOT);
   endproperty

   a_run_not_to_boot: assert property (p_run_not_to_boot)
      else $error("startup_sequencer: phase went RUN -> BOOT without OFF");

endmodule

// File: logic/dead_time_gen.sv
`timescale 1ns/1ps

module dead_time_gen
   import bridge_pkg::*;
(
   input  logic    ADA_DCO,
   input  logic    i_rst_n,
   input  gate_t   i_gate_req,
   input  dt_sel_t i_dt_sel,
   output gate_t   o_gate
);

   // =========================================================================
   // dead time selection
   // =========================================================================

   logic [DT_W-1:0] dt_len;
   // run count at which the output may turn on
   logic [DT_W-1:0] dt_last;

   always_comb begin
      case (i_dt_sel)
         DT_80:   dt_len = DT_W'(DT_CYC_80);
         DT_40:   dt_len = DT_W'(DT_CYC_40);
         DT_20:   dt_len = DT_W'(DT_CYC_20);
         DT_60:   dt_len = DT_W'(DT_CYC_60);
         // longest one if the code is ever unknown
         default: dt_len = DT_W'(DT_CYC_80);
      endcase
   end

   assign dt_last = dt_len - 1'b1;

   // =========================================================================
   // per-switch delay on the rising edge
   // =========================================================================

   logic [3:0]      req_v;
   logic [3:0]      out_v;
   // consecutive high samples of each request, saturating
   logic [DT_W-1:0] run_cnt [4];

   assign req_v = i_gate_req;

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 4; i++) begin
            run_cnt[i] <= '0;
            out_v[i]   <= 1'b0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (!req_v[i]) begin
               // falling edge goes straight through
               run_cnt[i] <= '0;
               out_v[i]   <= 1'b0;
            end else begin
               if (run_cnt[i] != '1) begin
                  run_cnt[i] <= run_cnt[i] + 1'b1;
               end
               // on at the Nth consecutive high sample
               // a new selection counts from the sample it is seen on
               out_v[i] <= (run_cnt[i] >= dt_last);
            end
         end
      end
   end

   assign o_gate = gate_t'(out_v);

   // =========================================================================
   // checks
   // =========================================================================

   // an output is only ever a delayed copy of its own request
   for (genvar g = 0; g < 4; g++) begin : g_chk
      a_out_needs_req: assert property (
         @(posedge ADA_DCO) disable iff (!i_rst_n)
            out_v[g] |-> $past(req_v[g])
      ) else $error("dead_time_gen: switch %0d on without request", g);
   end

endmodule

// File: logic/gate_driver.sv
`timescale 1ns/1ps

module gate_driver
   import bridge_pkg::*;
(
   input  logic   ADA_DCO,
   input  logic   i_rst_n,
   input  logic   i_enable,
   input  phase_t i_phase,
   input  gate_t  i_dt_gate,
   output gate_t  o_gate,
   output phase_t o_phase,
   output logic   o_fault
);

   // =========================================================================
   // pattern select and guard
   // =========================================================================

   // registered phase, also the status output
   phase_t phase_q;

   logic  leg1_short;
   logic  leg2_short;
   logic  short_any;
   gate_t sel_gate;
   gate_t safe_gate;

   // both switches of one leg requested together
   assign leg1_short = i_dt_gate.q1 & i_dt_gate.q3;
   assign leg2_short = i_dt_gate.q2 & i_dt_gate.q4;
   assign short_any  = leg1_short | leg2_short;

   // off / bootstrap / force sigma=1 / normal
   always_comb begin
      case (phase_q)
         PH_OFF:   sel_gate = '0;
         PH_BOOT:  sel_gate = GATE_BOOT;
         PH_FORCE: sel_gate = GATE_FORCE;
         PH_RUN:   sel_gate = i_dt_gate;
         default:  sel_gate = '0;
      endcase
   end

   // the short alert kills every phase, as on the board
   assign safe_gate = (short_any || !i_enable) ? gate_t'('0) : sel_gate;

   // =========================================================================
   // output register
   // =========================================================================

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase_q <= PH_OFF;
         o_gate  <= '0;
         o_fault <= 1'b0;
      end else begin
         phase_q <= i_phase;
         // gates trail the phase by one cycle
         o_gate  <= safe_gate;
         o_fault <= short_any;
      end
   end

   assign o_phase = phase_q;

   // boot and force patterns must be leg-safe as well as the guarded run one
   a_no_shoot_through: assert property (
      @(posedge ADA_DCO) disable iff (!i_rst_n)
         !((o_gate.q1 && o_gate.q3) || (o_gate.q2 && o_gate.q4))
   ) else $error("gate_driver: shoot-through on gates %b", o_gate);

endmodule

// File: logic/bridge_top.sv
`timescale 1ns/1ps

module bridge_top
   import bridge_pkg::*;
(
   input  logic    ADA_DCO,
   input  logic    i_rst_n,
   input  logic    i_enable,
   input  gate_t   i_gate_req,
   input  dt_sel_t i_dt_sel,
   output gate_t   o_gate,
   output phase_t  o_phase,
   output logic    o_fault
);

   // =========================================================================
   // internal wires
   // =========================================================================

   // look-ahead start-up phase
   phase_t phase;
   // requested pattern after dead time
   gate_t  dt_gate;

   // =========================================================================
   // blocks
   // =========================================================================

   // bootstrap charge, force, then run
   startup_sequencer u_startup_sequencer (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .o_phase  (phase)
   );

   // delay on every rising gate edge
   dead_time_gen u_dead_time_gen (
      .ADA_DCO    (ADA_DCO),
      .i_rst_n    (i_rst_n),
      .i_gate_req (i_gate_req),
      .i_dt_sel   (i_dt_sel),
      .o_gate     (dt_gate)
   );

   // pattern mux, guard, enable and the output flops
   gate_driver u_gate_driver (
      .ADA_DCO   (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_enable  (i_enable),
      .i_phase   (phase),
      .i_dt_gate (dt_gate),
      .o_gate    (o_gate),
      .o_phase   (o_phase),
      .o_fault   (o_fault)
   );

endmodule

// File: include/tb_bridge_model.svh
`ifndef TB_BRIDGE_MODEL_SVH
`define TB_BRIDGE_MODEL_SVH

// =========================================================================
// cycle model of the gate-drive path
// =========================================================================

// start-up prescaler and tick count
int         m_pre;
int         m_tick;
// consecutive high samples per switch
int         m_run [4];
// dead-timed pattern, registered phase and the output flops
logic [3:0] m_dt;
phase_t     m_phase;
gate_t      m_gate;
logic       m_fault;

// dead time in cycles for a selection code
function automatic int dt_cycles(input dt_sel_t sel);
   case (sel)
      DT_40:   return DT_CYC_40;
      DT_20:   return DT_CYC_20;
      DT_60:   return DT_CYC_60;
      default: return DT_CYC_80;
   endcase
endfunction

task automatic model_reset();
   m_pre   = 0;
   m_tick  = 0;
   m_dt    = '0;
   m_phase = PH_OFF;
   m_gate  = '0;
   m_fault = 1'b0;
   for (int i = 0; i < 4; i++) begin
      m_run[i] = 0;
   end
endtask

// one rising edge, inputs as sampled on that edge
task automatic model_step(input logic en, input gate_t req, input dt_sel_t sel);
   phase_t     nxt_phase;
   logic [3:0] nxt_dt;
   logic       leg_short;
   gate_t      pat;
   int         n;
   n = dt_cycles(sel);
   // phase decoded from the tick count before this edge
   if (!en) begin
      nxt_phase = PH_OFF;
   end else if (m_tick > VG_TICKS) begin
      nxt_phase = PH_RUN;
   end else if (m_tick > ON_TICKS) begin
      nxt_phase = PH_FORCE;
   end else begin
      nxt_phase = PH_BOOT;
   end
   // pattern follows the phase already in the output register
   case (m_phase)
      PH_BOOT:  pat = GATE_BOOT;
      PH_FORCE: pat = GATE_FORCE;
      PH_RUN:   pat = gate_t'(m_dt);
      default:  pat = '0;
   endcase
   // guard on both legs, then the enable gate
   leg_short = (m_dt[0] & m_dt[2]) | (m_dt[1] & m_dt[3]);
   if (leg_short || !en) begin
      pat = '0;
   end
   // rising edge waits for n high samples, falling edge passes
   for (int i = 0; i < 4; i++) begin
      if (!req[i]) begin
         m_run[i]  = 0;
         nxt_dt[i] = 1'b0;
      end else begin
         m_run[i]  = m_run[i] + 1;
         nxt_dt[i] = (m_run[i] >= n);
      end
   end
   // prescaler and saturating tick counter
   if (!en) begin
      m_pre  = 0;
      m_tick = 0;
   end else if (m_tick <= VG_TICKS) begin
      if (m_pre == STARTUP_DIV - 1) begin
         m_pre  = 0;
         m_tick = m_tick + 1;
      end else begin
         m_pre = m_pre + 1;
      end
   end
   m_phase = nxt_phase;
   m_gate  = pat;
   m_fault = leg_short;
   m_dt    = nxt_dt;
endtask

`endif

// File: bench/tb_bridge.sv
`timescale 1ns/1ps

module tb_bridge
   import bridge_pkg::*;
();

   // =========================================================================
   // run length
   // =========================================================================

   localparam int CLK_PERIOD = 10;
   localparam int NPAT       = 12;
   // longest random hold is twice the longest dead time
   localparam int HOLD_MAX   = 2 * DT_CYC_80;
   // enable to PH_RUN plus slack
   localparam int START_CYC  = (VG_TICKS + 1) * STARTUP_DIV + 8;
   // reset, idle, start-up, four selections, shoot-through, four start-ups
   localparam int BUDGET     = 4 + 10 + START_CYC
                               + 4 * (DT_CYC_80 + 8 + NPAT * HOLD_MAX)
                               + 2 * HOLD_MAX + 4 * (START_CYC + 8);
   localparam int MARGIN     = 200;

   logic    ADA_DCO;
   logic    rst_n;
   logic    enable;
   gate_t   gate_req;
   dt_sel_t dt_sel;
   gate_t   o_gate;
   phase_t  o_phase;
   logic    o_fault;

   int seed;
   int err_cnt;
   int pass_cnt;
   int fail_cnt;

   `include "tb_bridge_model.svh"

   bridge_top u_bridge_top (
      .ADA_DCO    (ADA_DCO),
      .i_rst_n    (rst_n),
      .i_enable   (enable),
      .i_gate_req (gate_req),
      .i_dt_sel   (dt_sel),
      .o_gate     (o_gate),
      .o_phase    (o_phase),
      .o_fault    (o_fault)
   );

   initial ADA_DCO = 1'b0;
   always #(CLK_PERIOD / 2) ADA_DCO = ~ADA_DCO;

   // =========================================================================
   // helpers
   // =========================================================================

   task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         $display("ERROR %s expected 0x%h got 0x%h at %0t ns", name, exp, act, $time);
         err_cnt++;
      end
   endtask

   // one clock with the model in step and outputs checked 1 ns after the edge
   task automatic tick();
      @(posedge ADA_DCO);
      model_step(enable, gate_req, dt_sel);
      #1;
      expect_value("o_gate", 8'(m_gate), 8'(o_gate));
      expect_value("o_phase", 8'(m_phase), 8'(o_phase));
      expect_value("o_fault", 8'(m_fault), 8'(o_fault));
   endtask

   task automatic wait_phase(input phase_t target, output int cyc);
      cyc = 0;
      while (o_phase !== target && cyc < START_CYC) begin
         tick();
         cyc++;
      end
      assert (o_phase === target) else begin
         $display("phase %s never showed up within %0d cycles", target.name(), START_CYC);
         err_cnt++;
      end
   endtask

   // boot on the first enabled edge and force and run after whole ticks
   task automatic check_startup_timing();
      int cyc;
      wait_phase(PH_BOOT, cyc);
      expect_value("boot delay", 8'd1, 8'(cyc));
      wait_phase(PH_FORCE, cyc);
      expect_value("force delay", 8'((ON_TICKS + 1) * STARTUP_DIV), 8'(cyc));
      wait_phase(PH_RUN, cyc);
      expect_value("run delay", 8'((VG_TICKS - ON_TICKS) * STARTUP_DIV), 8'(cyc));
   endtask

   // single q1 pulse that rises after n+1 and falls after 2
   task automatic check_edge_latency(input int n);
      int cyc;
      gate_req = '0;
      repeat (3) tick();
      gate_req = gate_t'(4'b0001);
      cyc = 0;
      while (!o_gate.q1 && cyc < n + 8) begin
         tick();
         cyc++;
      end
      expect_value("o_gate.q1 rise latency", 8'(n + 1), 8'(cyc));
      gate_req = '0;
      cyc = 0;
      while (o_gate.q1 && cyc < 8) begin
         tick();
         cyc++;
      end
      expect_value("o_gate.q1 fall latency", 8'd2, 8'(cyc));
   endtask

   // at most one switch per leg
   function automatic gate_t safe_pattern(input int leg1, input int leg2);
      gate_t g;
      g = '0;
      if (leg1 == 1) g.q1 = 1'b1;
      if (leg1 == 2) g.q3 = 1'b1;
      if (leg2 == 1) g.q2 = 1'b1;
      if (leg2 == 2) g.q4 = 1'b1;
      return g;
   endfunction

   task automatic finish_test(input string name, input int start_err);
      if (err_cnt == start_err) begin
         pass_cnt++;
         $display("test %s passed", name);
      end else begin
         fail_cnt++;
         $display("test %s failed with %0d errors", name, err_cnt - start_err);
      end
   endtask

   // =========================================================================
   // tests
   // =========================================================================

   initial begin
      int start_err;
      int hold;
      int n;
      seed     = 32'h2813_d49e;
      err_cnt  = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      rst_n    = 1'b0;
      enable   = 1'b0;
      gate_req = '0;
      dt_sel   = DT_80;
      model_reset();
      repeat (4) @(posedge ADA_DCO);
      #1;
      rst_n = 1'b1;

      // idle after reset
      start_err = err_cnt;
      gate_req  = gate_t'(4'b0011);
      repeat (10) tick();
      finish_test("reset_idle", start_err);

      // bootstrap, force, run
      start_err = err_cnt;
      gate_req  = '0;
      enable    = 1'b1;
      check_startup_timing();
      finish_test("startup_sequence", start_err);

      // random leg-safe patterns per dead time
      start_err = err_cnt;
      for (int s = 0; s < 4; s++) begin
         dt_sel = dt_sel_t'(s);
         n      = dt_cycles(dt_sel);
         check_edge_latency(n);
         for (int p = 0; p < NPAT; p++) begin
            gate_req = safe_pattern({$random(seed)} % 3, {$random(seed)} % 3);
            hold     = 1 + {$random(seed)} % (2 * n);
            repeat (hold) tick();
         end
      end
      finish_test("random_dead_time", start_err);

      // both switches of leg 1 past the dead time
      start_err = err_cnt;
      dt_sel    = DT_20;
      gate_req  = gate_t'(4'b0101);
      repeat (DT_CYC_20 + 6) tick();
      expect_value("o_fault", 8'h1, 8'(o_fault));
      expect_value("o_gate", 8'h0, 8'(o_gate));
      gate_req = gate_t'(4'b0001);
      repeat (6) tick();
      expect_value("o_fault", 8'h0, 8'(o_fault));
      expect_value("o_gate", 8'h1, 8'(o_gate));
      // both switches of leg 2
      gate_req = gate_t'(4'b1010);
      repeat (DT_CYC_20 + 6) tick();
      expect_value("o_fault", 8'h1, 8'(o_fault));
      expect_value("o_gate", 8'h0, 8'(o_gate));
      gate_req = gate_t'(4'b0001);
      repeat (6) tick();
      expect_value("o_fault", 8'h0, 8'(o_fault));
      finish_test("shoot_through", start_err);

      // drop enable in each phase and then restart fully
      start_err = err_cnt;
      for (int k = 1; k < 4; k++) begin
         enable = 1'b0;
         repeat (2) tick();
         enable = 1'b1;
         wait_phase(phase_t'(k), hold);
         repeat (3) tick();
         enable = 1'b0;
         tick();
         expect_value("o_phase", 8'(PH_OFF), 8'(o_phase));
         tick();
         expect_value("o_gate", 8'h0, 8'(o_gate));
      end
      enable = 1'b1;
      check_startup_timing();
      finish_test("enable_drop", start_err);

      $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // =========================================================================
   // watchdog
   // =========================================================================

   initial begin
      #((BUDGET + MARGIN) * CLK_PERIOD);
      $display("timeout after %0d cycles, the tests did not finish", BUDGET + MARGIN);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: list.f
+incdir+include
logic/bridge_pkg.sv
logic/startup_sequencer.sv
logic/dead_time_gen.sv
logic/gate_driver.sv
logic/bridge_top.sv
bench/tb_bridge.sv
